// File: hdl/cacheGeomPkg.sv
package cacheGeomPkg;

    // fetch address width, also the physical address width
    localparam int addrWidth = 32;

    // the age tree in plruTracker is built for exactly four ways
    localparam int wayCount = 4;

    // 16-byte lines of four words
    localparam int wordsPerLine = 4;
    localparam int offsetBits = 4;

    typedef logic [31:0] instWord;

    // word 0 sits in the lowest bits
    typedef logic [127:0] cacheLine;

    // one-hot, one bit per way
    typedef logic [wayCount-1:0] wayVec;

    typedef logic [1:0] wayIndex;

endpackage

// File: hdl/fetchControl.sv
`timescale 1ns/1ps

module fetchControl #(
    parameter int setBits = 6
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fetchValid,
    input  logic [cacheGeomPkg::addrWidth-1:0]   fetchPc,
    input  logic                                 flush,
    input  cacheGeomPkg::wayVec                  hitWay,
    input  cacheGeomPkg::wayIndex                victimWay,
    input  logic                                 memRespValid,
    output logic [cacheGeomPkg::addrWidth-1:0]   lookupPc,
    output logic                                 lookupActive,
    output logic                                 fillEn,
    output logic                                 touchEn,
    output cacheGeomPkg::wayIndex                touchWay,
    output logic                                 instValid,
    output logic                                 busy,
    output logic                                 memReqValid,
    output logic [cacheGeomPkg::addrWidth-1:0]   memReqAddr
);

    localparam int tagBits = cacheGeomPkg::addrWidth - setBits - cacheGeomPkg::offsetBits;

    fetchCtrlPkg::fetchState state;
    fetchCtrlPkg::fetchState nextState;
    cacheGeomPkg::wayIndex   hitIndex;
    logic                    lookupHit;
    logic                    lookupMiss;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetchCtrlPkg::sLookup;
            lookupActive <= 1'b0;
        end else begin
            state <= nextState;
            lookupActive <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            lookupPc <= fetchPc;
        end
    end

    assign lookupHit  = state == fetchCtrlPkg::sLookup && lookupActive && |hitWay;
    assign lookupMiss = state == fetchCtrlPkg::sLookup && lookupActive && !(|hitWay);

    // a miss that meets a flush is simply dropped
    assign memReqValid = lookupMiss && !flush;
    assign memReqAddr  = {lookupPc[cacheGeomPkg::addrWidth-1 -: tagBits],
                          lookupPc[cacheGeomPkg::offsetBits +: setBits],
                          {cacheGeomPkg::offsetBits{1'b0}}};
    assign busy = state != fetchCtrlPkg::sLookup || memReqValid;

    always_comb begin
        nextState = state;
        fillEn = 1'b0;
        case (state)
            fetchCtrlPkg::sLookup: begin
                if (memReqValid) begin
                    nextState = fetchCtrlPkg::sRefill;
                end
            end
            fetchCtrlPkg::sRefill: begin
                if (memRespValid) begin
                    nextState = fetchCtrlPkg::sLookup;
                    fillEn = !flush;
                end else if (flush) begin
                    nextState = fetchCtrlPkg::sDiscard;
                end
            end
            fetchCtrlPkg::sDiscard: begin
                if (memRespValid) begin
                    nextState = fetchCtrlPkg::sLookup;
                end
            end
            default: nextState = fetchCtrlPkg::sLookup;
        endcase
    end

    always_comb begin
        hitIndex = '0;
        for (int w = 0; w < cacheGeomPkg::wayCount; w++) begin
            if (hitWay[w]) begin
                hitIndex = cacheGeomPkg::wayIndex'(w);
            end
        end
    end

    // on a refill the returned word comes straight from the response line
    assign instValid = (lookupHit && !flush) || fillEn;
    assign touchEn   = lookupHit || fillEn;
    assign touchWay  = fillEn ? victimWay : hitIndex;

    assert property (@(posedge clk) disable iff (rst) busy |-> !fetchValid)
        else $error("fetchControl: fetch strobe while busy");

    assert property (@(posedge clk) disable iff (rst)
        memRespValid |-> state != fetchCtrlPkg::sLookup)
        else $error("fetchControl: memory response with no refill outstanding");

    assert property (@(posedge clk) disable iff (rst) $onehot0(hitWay))
        else $error("fetchControl: more than one way hits");

endmodule

// File: hdl/fetchCtrlPkg.sv
package fetchCtrlPkg;

    // sDiscard waits out a refill that a flush has cancelled
    typedef enum logic [1:0] {
        sLookup,
        sRefill,
        sDiscard
    } fetchState;

endpackage

// File: hdl/iCacheTop.sv
`timescale 1ns/1ps

module iCacheTop #(
    parameter int setBits = 6
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fetchValid,
    input  logic [cacheGeomPkg::addrWidth-1:0]   fetchPc,
    input  logic                                 flush,
    output logic                                 instValid,
    output cacheGeomPkg::instWord                instData,
    output logic                                 busy,
    output logic                                 memReqValid,
    output logic [cacheGeomPkg::addrWidth-1:0]   memReqAddr,
    input  logic                                 memRespValid,
    input  cacheGeomPkg::cacheLine               memRespLine
);

    logic [cacheGeomPkg::addrWidth-1:0] lookupPc;
    logic                               lookupActive;
    logic                               fillEn;
    logic                               touchEn;
    cacheGeomPkg::wayVec                hitWay;
    cacheGeomPkg::wayIndex              victimWay;
    cacheGeomPkg::wayIndex              touchWay;
    logic [setBits-1:0]                 readSet;

    // both arrays start their read in the strobe cycle
    assign readSet = fetchPc[cacheGeomPkg::offsetBits +: setBits];

    fetchControl #(.setBits(setBits)) u_fetchControl (
        .clk          (clk),
        .rst          (rst),
        .fetchValid   (fetchValid),
        .fetchPc      (fetchPc),
        .flush        (flush),
        .hitWay       (hitWay),
        .victimWay    (victimWay),
        .memRespValid (memRespValid),
        .lookupPc     (lookupPc),
        .lookupActive (lookupActive),
        .fillEn       (fillEn),
        .touchEn      (touchEn),
        .touchWay     (touchWay),
        .instValid    (instValid),
        .busy         (busy),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr)
    );

    tagArray #(.setBits(setBits)) u_tagArray (
        .clk          (clk),
        .rst          (rst),
        .readSet      (readSet),
        .lookupPc     (lookupPc),
        .lookupActive (lookupActive),
        .fillEn       (fillEn),
        .victimWay    (victimWay),
        .hitWay       (hitWay)
    );

    lineArray #(.setBits(setBits)) u_lineArray (
        .clk         (clk),
        .readSet     (readSet),
        .lookupPc    (lookupPc),
        .hitWay      (hitWay),
        .fillEn      (fillEn),
        .victimWay   (victimWay),
        .memRespLine (memRespLine),
        .instData    (instData)
    );

    plruTracker #(.setBits(setBits)) u_plruTracker (
        .clk       (clk),
        .rst       (rst),
        .lookupPc  (lookupPc),
        .touchEn   (touchEn),
        .touchWay  (touchWay),
        .victimWay (victimWay)
    );

endmodule

// File: hdl/lineArray.sv
`timescale 1ns/1ps

module lineArray #(
    parameter int setBits = 6
) (
    input  logic                                 clk,
    input  logic [setBits-1:0]                   readSet,
    input  logic [cacheGeomPkg::addrWidth-1:0]   lookupPc,
    input  cacheGeomPkg::wayVec                  hitWay,
    input  logic                                 fillEn,
    input  cacheGeomPkg::wayIndex                victimWay,
    input  cacheGeomPkg::cacheLine               memRespLine,
    output cacheGeomPkg::instWord                instData
);

    localparam int setCount  = 1 << setBits;
    localparam int wordBits  = $bits(cacheGeomPkg::instWord);
    localparam int wordIdxW  = $clog2(cacheGeomPkg::wordsPerLine);

    logic [setBits-1:0]     lookupSet;
    logic [wordIdxW-1:0]    wordSel;
    cacheGeomPkg::cacheLine maskedLine [cacheGeomPkg::wayCount];
    cacheGeomPkg::cacheLine selLine;

    assign lookupSet = lookupPc[cacheGeomPkg::offsetBits +: setBits];
    assign wordSel   = lookupPc[2 +: wordIdxW];

    for (genvar w = 0; w < cacheGeomPkg::wayCount; w++) begin : gWay
        cacheGeomPkg::cacheLine lineMem [setCount];
        cacheGeomPkg::cacheLine lineRd;

        always_ff @(posedge clk) begin
            if (fillEn && victimWay == w) begin
                lineMem[lookupSet] <= memRespLine;
            end
            lineRd <= lineMem[readSet];
        end

        assign maskedLine[w] = hitWay[w] ? lineRd : '0;
    end

    // refill bypass takes priority, hitWay is zero then anyway
    always_comb begin
        selLine = '0;
        for (int w = 0; w < cacheGeomPkg::wayCount; w++) begin
            selLine = selLine | maskedLine[w];
        end
        if (fillEn) begin
            selLine = memRespLine;
        end
    end

    assign instData = selLine[wordSel*wordBits +: wordBits];

endmodule

// File: hdl/plruTracker.sv
`timescale 1ns/1ps

module plruTracker #(
    parameter int setBits = 6
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [cacheGeomPkg::addrWidth-1:0]   lookupPc,
    input  logic                                 touchEn,
    input  cacheGeomPkg::wayIndex                touchWay,
    output cacheGeomPkg::wayIndex                victimWay
);

    localparam int setCount = 1 << setBits;

    // b0 picks the half, b1 and b2 the way inside each half
    logic [2:0]         ageBits [setCount];
    logic [2:0]         curAge;
    logic [setBits-1:0] lookupSet;

    assign lookupSet = lookupPc[cacheGeomPkg::offsetBits +: setBits];
    assign curAge    = ageBits[lookupSet];

    always_comb begin
        if (curAge[0]) begin
            victimWay = curAge[1] ? 2'd0 : 2'd1;
        end else begin
            victimWay = curAge[2] ? 2'd2 : 2'd3;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < setCount; s++) begin
                ageBits[s] <= '0;
            end
        end else if (touchEn) begin
            case (touchWay)
                2'd0: ageBits[lookupSet][1:0] <= 2'b00;
                2'd1: ageBits[lookupSet][1:0] <= 2'b10;
                2'd2: begin
                    ageBits[lookupSet][0] <= 1'b1;
                    ageBits[lookupSet][2] <= 1'b0;
                end
                default: begin
                    ageBits[lookupSet][0] <= 1'b1;
                    ageBits[lookupSet][2] <= 1'b1;
                end
            endcase
        end
    end

endmodule

// File: hdl/tagArray.sv
`timescale 1ns/1ps

module tagArray #(
    parameter int setBits = 6
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [setBits-1:0]                   readSet,
    input  logic [cacheGeomPkg::addrWidth-1:0]   lookupPc,
    input  logic                                 lookupActive,
    input  logic                                 fillEn,
    input  cacheGeomPkg::wayIndex                victimWay,
    output cacheGeomPkg::wayVec                  hitWay
);

    localparam int tagBits  = cacheGeomPkg::addrWidth - setBits - cacheGeomPkg::offsetBits;
    localparam int setCount = 1 << setBits;

    logic [setBits-1:0]  lookupSet;
    logic [tagBits-1:0]  lookupTag;
    cacheGeomPkg::wayVec fillMatch;

    assign lookupSet = lookupPc[cacheGeomPkg::offsetBits +: setBits];
    assign lookupTag = lookupPc[cacheGeomPkg::addrWidth-1 -: tagBits];

    for (genvar w = 0; w < cacheGeomPkg::wayCount; w++) begin : gWay
        logic [tagBits-1:0]  tagMem [setCount];
        logic [tagBits-1:0]  tagRd;
        logic [setCount-1:0] validBits;

        always_ff @(posedge clk) begin
            if (fillEn && victimWay == w) begin
                tagMem[lookupSet] <= lookupTag;
            end
            tagRd <= tagMem[readSet];
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                validBits <= '0;
            end else if (fillEn && victimWay == w) begin
                validBits[lookupSet] <= 1'b1;
            end
        end

        // tag was read in the strobe cycle, valid is current
        assign hitWay[w] = lookupActive && validBits[lookupSet] && tagRd == lookupTag;

        assign fillMatch[w] = validBits[lookupSet] && tagMem[lookupSet] == lookupTag;
    end

    // lookupPc still holds the filled address one cycle on
    assert property (@(posedge clk) disable iff (rst) fillEn |=> $onehot(fillMatch))
        else $error("tagArray: filled line does not match exactly one way");

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module iCacheTb -o iCacheSim

output=$(./obj_dir/iCacheSim 2>&1) || true
printf '%s\n' "$output"

# pass only when the testbench printed its pass line
printf '%s\n' "$output" | grep -q "TEST PASSED"

// File: sim.f
hdl/cacheGeomPkg.sv
hdl/fetchCtrlPkg.sv
hdl/fetchControl.sv
hdl/tagArray.sv
hdl/lineArray.sv
hdl/plruTracker.sv
hdl/iCacheTop.sv
tests/memModel.sv
tests/iCacheTb.sv

// File: tests/iCacheTb.sv
`timescale 1ns/1ps

module iCacheTb;

    localparam int setBits = 6;
    localparam int tagShift = 4 + setBits;
    // fetches issued by all tests together, a miss needs at most 12 cycles
    localparam int fetchTotal = 316;
    // ways filled in one set from zero age bits, the fifth fill evicts the first
    localparam int fillOrder [5] = '{3, 1, 2, 0, 3};

    logic         clk;
    logic         rst;
    logic         fetchValid;
    logic [31:0]  fetchPc;
    logic         flush;
    logic         instValid;
    logic [31:0]  instData;
    logic         busy;
    logic         memReqValid;
    logic [31:0]  memReqAddr;
    logic         memRespValid;
    logic [127:0] memRespLine;

    // reference cache, tags kept as the address shifted down
    logic [31:0] refTag [1 << setBits][4];
    logic        refValid [1 << setBits][4];
    logic [2:0]  refAge [1 << setBits];
    logic [31:0] expWords [$];
    logic [31:0] expLine = '0;
    int          errors = 0;
    int          reqCount = 0;
    int          markErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          way;

    iCacheTop #(.setBits(setBits)) u_iCacheTop (.*);
    memModel u_memModel (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected memory content of a word address
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = addr ^ 32'hC0DE_0000;
        return {mixed[28:0], mixed[31:29]};
    endfunction

    function automatic int refFind(input logic [31:0] pc);
        logic [setBits-1:0] s;
        int found;
        s = pc[4 +: setBits];
        found = -1;
        for (int w = 0; w < 4; w++) begin
            if (refValid[s][w] && refTag[s][w] == pc >> tagShift) begin
                found = w;
            end
        end
        return found;
    endfunction

    task automatic refTouch(input logic [setBits-1:0] s, input int w);
        refAge[s][0] = (w >= 2);
        if (w < 2) begin
            refAge[s][1] = (w == 1);
        end else begin
            refAge[s][2] = (w == 3);
        end
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // mode 1 flushes the lookup result, mode 2 flushes the refill
    task automatic fetchOne(input logic [31:0] pc, input int mode, output int used);
        logic [setBits-1:0] s;
        int reqBefore;
        s = pc[4 +: setBits];
        used = refFind(pc);
        reqBefore = reqCount;
        expLine = pc & ~32'hF;
        if (mode == 0) begin
            expWords.push_back(memWord(pc));
        end
        fetchValid <= 1'b1;
        fetchPc <= pc;
        @(posedge clk);
        fetchValid <= 1'b0;
        flush <= (mode == 1);
        @(posedge clk);
        flush <= (mode == 2);
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        checkEq(reqCount - reqBefore, (used < 0) ? 32'd1 : 32'd0, "request count");
        if (expWords.size() != 0) begin
            errors++;
            $display("no instruction came back for pc %h", pc);
            expWords.delete();
        end
        if (used >= 0) begin
            refTouch(s, used);
        end else if (mode != 2) begin
            used = refAge[s][0] ? (refAge[s][1] ? 0 : 1) : (refAge[s][2] ? 2 : 3);
            refTag[s][used] = pc >> tagShift;
            refValid[s][used] = 1'b1;
            refTouch(s, used);
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errors == markErrors) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errors - markErrors);
        end
        markErrors = errors;
    endtask

    // every returned word and every memory request
    always @(negedge clk) begin
        if (!rst && memReqValid) begin
            reqCount++;
            checkEq(memReqAddr, expLine, "request address");
        end
        if (!rst && instValid) begin
            if (expWords.size() == 0) begin
                errors++;
                $display("unexpected instruction %h at %0t ns", instData, $time);
            end else begin
                checkEq(instData, expWords.pop_front(), "instruction word");
            end
        end
    end

    initial begin
        repeat (16 + fetchTotal * 12 + 100) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] pc;
        int markReq;
        void'($urandom(32900));
        refValid = '{default: 1'b0};
        refAge = '{default: 3'b000};
        rst <= 1'b1;
        fetchValid <= 1'b0;
        fetchPc <= '0;
        flush <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq({29'b0, busy, instValid, memReqValid}, 32'd0, "outputs after reset");
        @(posedge clk);
        fetchOne(32'h0000_1234, 0, way);
        endTest("cold miss");

        // whole line back to back, one word per cycle
        markReq = reqCount;
        refTouch(6'h23, refFind(32'h0000_1230));
        for (int i = 0; i < 4; i++) begin
            expWords.push_back(memWord(32'h0000_1230 + 32'(4 * i)));
            fetchValid <= 1'b1;
            fetchPc <= 32'h0000_1230 + 32'(4 * i);
            @(posedge clk);
        end
        fetchValid <= 1'b0;
        repeat (2) @(posedge clk);
        checkEq(reqCount - markReq, 32'd0, "request count");
        checkEq(32'(expWords.size()), 32'd0, "words still missing");
        expWords.delete();
        endTest("line hits");

        for (int t = 1; t <= 5; t++) begin
            fetchOne(32'(t << tagShift) | 32'h58, 0, way);
            checkEq(way, 32'(fillOrder[t - 1]), "filled way");
        end
        // tag 1 was evicted, tag 3 stays in way 2
        fetchOne(32'(1 << tagShift) | 32'h58, 0, way);
        fetchOne(32'(3 << tagShift) | 32'h58, 0, way);
        checkEq(way, 32'd2, "hit way");
        endTest("replacement");

        fetchOne(32'h0000_0494, 2, way);
        fetchOne(32'h0000_0494, 0, way);
        endTest("flush during refill");

        fetchOne(32'h0000_0494, 1, way);
        fetchOne(32'h0000_0498, 0, way);
        endTest("flush with hit");

        for (int n = 0; n < 300; n++) begin
            pc = ($urandom_range(5, 0) << tagShift) | ($urandom_range(3, 0) << 4);
            pc = pc | ($urandom_range(3, 0) << 2);
            fetchOne(pc, 0, way);
        end
        endTest("random stream");

        $display("tests run %0d, failed %0d, failed checks %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/memModel.sv
`timescale 1ns/1ps

module memModel (
    input  logic         clk,
    input  logic         rst,
    input  logic         memReqValid,
    input  logic [31:0]  memReqAddr,
    output logic         memRespValid,
    output logic [127:0] memRespLine
);

    logic        pending = 1'b0;
    logic [31:0] pendAddr = '0;
    int          waitLeft = 0;

    // memory content, a fixed scramble of the word address
    function automatic logic [31:0] contentWord(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = addr ^ 32'hC0DE_0000;
        return {mixed[28:0], mixed[31:29]};
    endfunction

    initial begin
        memRespValid <= 1'b0;
        memRespLine <= '0;
    end

    always @(posedge clk) begin
        memRespValid <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
            waitLeft <= 0;
        end else if (pending) begin
            if (waitLeft == 0) begin
                memRespValid <= 1'b1;
                for (int i = 0; i < 4; i++) begin
                    memRespLine[32*i +: 32] <= contentWord(pendAddr + 32'(4 * i));
                end
                pending <= 1'b0;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end else if (memReqValid) begin
            pending <= 1'b1;
            pendAddr <= memReqAddr;
            // answer lands 2 to 9 cycles after the request cycle
            waitLeft <= int'($urandom_range(7, 0));
        end
    end

endmodule
